// File: files.f
rtl/audFilterPkg.sv
rtl/biquadSection.sv
rtl/powerMeter.sv
rtl/coefRegs.sv
rtl/lowPassChannel.sv
rtl/audFilterTop.sv
verification/audFilter_checker.sv
verification/audFilterTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module audFilterTb -f files.f

result=$(./obj_dir/VaudFilterTb 2>&1) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'RESULT: PASS'; then
	exit 0
fi
exit 1

// File: verification/audFilterTb.sv
`default_nettype none

module audFilterTb import audFilterPkg::*; ();

	localparam int Window = 64;
	localparam int Shift = 4;
	// Several times the length of all tests
	localparam int CycleLimit = 4000;

	logic aud_clk;
	logic reset;
	axiLiteReq axiReq;
	axiLiteRsp axiRsp;
	logic signed [SampleWidth-1:0] audIn;
	logic audInValid;
	wideSample audOut;
	logic audOutValid;
	logic [PowerWidth-1:0] power;

	// Reference model state, coefficient index = section * 5 + tap
	longint modelCoef [10];
	longint histX1 [2];
	longint histX2 [2];
	longint histY1 [2];
	longint histY2 [2];
	longint powerSum;
	int powerCount;
	logic modelEnable;
	logic [PowerWidth-1:0] expPower;
	// Expected outputs still inside the two-stage pipeline
	logic pipeValid [2];
	wideSample pipeData [2];
	logic [31:0] lcgState;
	int cycleCount = 0;

	audFilterTop #(
		.PowerWindow(Window),
		.PowerShift(Shift)
	) i_dut (
		.aud_clk(aud_clk),
		.reset(reset),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.audIn(audIn),
		.audInValid(audInValid),
		.audOut(audOut),
		.audOutValid(audOutValid),
		.power(power)
	);

	bind audFilterTop audFilter_checker i_checker (
		.aud_clk(aud_clk),
		.reset(reset),
		.enable(enable),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.audInValid(audInValid),
		.audOutValid(audOutValid),
		.audOut(audOut),
		.power(power)
	);

	initial begin
		aud_clk = 1'b0;
		forever #20 aud_clk = ~aud_clk;
	end

	always @(posedge aud_clk) begin
		cycleCount++;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", CycleLimit);
			abortRun();
		end
	end

	task automatic abortRun();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic compareSample(input wideSample got, input wideSample exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic compareReg(input logic [31:0] got, input logic [31:0] exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic comparePower(input logic [PowerWidth-1:0] got,
		input logic [PowerWidth-1:0] exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic compareResp(input logic [1:0] got, input logic [1:0] exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic compareFlag(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			abortRun();
		end
	endtask

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic signed [SampleWidth-1:0] randomSample();
		logic [31:0] r;
		r = lcgNext();
		return r[31:16];
	endfunction

	// One of -1, 0, 1
	function automatic logic signed [SampleWidth-1:0] smallSample();
		int v;
		v = int'(lcgNext() % 32'd3) - 1;
		return 16'(v);
	endfunction

	// Reset set, Q3.23
	function automatic wideSample defaultCoef(input int idx);
		case (idx)
			0: return 27'h14762;
			1: return 27'h7FD7142;
			2: return 27'h14762;
			3: return 27'h7002F9B;
			4: return 27'h7FD076;
			5: return 27'h800000;
			6: return 27'h7000080;
			7: return 27'h800000;
			8: return 27'h7000D3D;
			default: return 27'h7FF2FA;
		endcase
	endfunction

	// Mild low-pass, DC gain one in each section
	function automatic wideSample newCoef(input int idx);
		case (idx)
			0: return 27'h400000;
			1: return 27'h200000;
			3: return 27'h7E00000;
			5: return 27'h600000;
			6: return 27'h100000;
			7: return 27'h100000;
			default: return 27'h0;
		endcase
	endfunction

	function automatic logic [7:0] coefAddr(input int idx);
		return 8'h04 + 8'(4 * idx);
	endfunction

	// Keep the low 27 bits as a signed value
	function automatic longint wrap27(input longint v);
		longint t;
		t = v & 64'h7FF_FFFF;
		if (t >= 64'h400_0000) begin
			t = t - 64'h800_0000;
		end
		return t;
	endfunction

	function automatic longint runSection(input int s, input longint x);
		longint acc;
		longint y;
		acc = modelCoef[s*5] * x + modelCoef[s*5+1] * histX1[s] + modelCoef[s*5+2] * histX2[s]
			- modelCoef[s*5+3] * histY1[s] - modelCoef[s*5+4] * histY2[s];
		y = wrap27(acc >>> 23);
		histX2[s] = histX1[s];
		histX1[s] = x;
		histY2[s] = histY1[s];
		histY1[s] = y;
		return y;
	endfunction

	// Input widened by 8 fraction bits, then both sections
	function automatic wideSample modelFilter(input logic signed [SampleWidth-1:0] s);
		longint y0;
		y0 = runSection(0, longint'(s) * 256);
		return 27'(runSection(1, y0));
	endfunction

	function automatic void clearModel();
		for (int s = 0; s < 2; s++) begin
			histX1[s] = 0;
			histX2[s] = 0;
			histY1[s] = 0;
			histY2[s] = 0;
		end
		powerSum = 0;
		powerCount = 0;
		expPower = '0;
	endfunction

	// Magnitude sum over the window, shifted and saturated
	function automatic void meterSample(input wideSample y);
		longint mag;
		longint level;
		mag = longint'(y);
		if (mag < 0) begin
			mag = -mag;
		end
		powerSum += mag;
		powerCount++;
		if (powerCount == Window) begin
			level = powerSum >>> Shift;
			expPower = (level > 2047) ? 11'h7FF : level[10:0];
			powerSum = 0;
			powerCount = 0;
		end
	endfunction

	// Check what the last edge produced, then drive the next input
	task automatic sampleStep(input logic v, input logic signed [SampleWidth-1:0] s);
		@(negedge aud_clk);
		comparePower(power, expPower, "power");
		compareFlag(audOutValid, pipeValid[1], "audOutValid");
		if (pipeValid[1]) begin
			compareSample(audOut, pipeData[1], "audOut");
			meterSample(pipeData[1]);
		end else if (!modelEnable) begin
			compareSample(audOut, '0, "audOut");
		end
		pipeValid[1] = pipeValid[0];
		pipeData[1] = pipeData[0];
		pipeValid[0] = v && modelEnable;
		if (v && modelEnable) begin
			pipeData[0] = modelFilter(s);
		end
		audIn = s;
		audInValid = v;
	endtask

	// Idle until the pipeline and the power update have drained
	task automatic flush();
		repeat (3) sampleStep(1'b0, '0);
	endtask

	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int readyDelay, output logic [1:0] resp);
		@(negedge aud_clk);
		axiReq.awvalid = 1'b1;
		axiReq.awaddr = addr;
		axiReq.wvalid = 1'b1;
		axiReq.wdata = data;
		axiReq.wstrb = strb;
		// Address and data taken together on an edge with both readies high
		do begin
			@(posedge aud_clk);
		end while (!(axiRsp.awready && axiRsp.wready));
		@(negedge aud_clk);
		axiReq.awvalid = 1'b0;
		axiReq.wvalid = 1'b0;
		// Response raised one cycle after acceptance
		compareFlag(axiRsp.bvalid, 1'b1, "bvalid");
		resp = axiRsp.bresp;
		repeat (readyDelay) begin
			@(negedge aud_clk);
			compareFlag(axiRsp.bvalid, 1'b1, "bvalid");
			compareResp(axiRsp.bresp, resp, "bresp");
		end
		axiReq.bready = 1'b1;
		@(negedge aud_clk);
		axiReq.bready = 1'b0;
		compareFlag(axiRsp.bvalid, 1'b0, "bvalid");
	endtask

	task automatic axiRead(input logic [7:0] addr, input int readyDelay,
		output logic [31:0] data, output logic [1:0] resp);
		@(negedge aud_clk);
		axiReq.arvalid = 1'b1;
		axiReq.araddr = addr;
		// Address taken on an edge with arready high
		do begin
			@(posedge aud_clk);
		end while (!axiRsp.arready);
		@(negedge aud_clk);
		axiReq.arvalid = 1'b0;
		compareFlag(axiRsp.rvalid, 1'b1, "rvalid");
		data = axiRsp.rdata;
		resp = axiRsp.rresp;
		// Held response must not move, and no new read is taken meanwhile
		repeat (readyDelay) begin
			@(negedge aud_clk);
			compareFlag(axiRsp.rvalid, 1'b1, "rvalid");
			compareFlag(axiRsp.arready, 1'b0, "arready");
			compareReg(axiRsp.rdata, data, "rdata");
			compareResp(axiRsp.rresp, resp, "rresp");
		end
		axiReq.rready = 1'b1;
		@(negedge aud_clk);
		axiReq.rready = 1'b0;
		compareFlag(axiRsp.rvalid, 1'b0, "rvalid");
	endtask

	task automatic writeReg(input logic [7:0] addr, input logic [31:0] data, input logic [3:0] strb);
		logic [1:0] resp;
		axiWrite(addr, data, strb, 0, resp);
		compareResp(resp, 2'b00, "bresp");
	endtask

	task automatic readCheck(input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(addr, 0, data, resp);
		compareResp(resp, 2'b00, "rresp");
		compareReg(data, exp, "rdata");
	endtask

	// Reads come back sign-extended from 27 bits
	task automatic coefCheck(input int idx, input wideSample c);
		readCheck(coefAddr(idx), {{5{c[26]}}, c});
	endtask

	task automatic setEnable(input logic v);
		writeReg(8'h00, {31'b0, v}, 4'hF);
		modelEnable = v;
		if (!v) begin
			clearModel();
		end
	endtask

	task automatic testResetState();
		readCheck(8'h00, 32'h0);
		for (int i = 0; i < 10; i++) begin
			coefCheck(i, defaultCoef(i));
		end
		// Strobes before enable stay silent
		repeat (8) sampleStep(1'b1, 16'sh1234);
		flush();
	endtask

	task automatic testDefaultResponse();
		setEnable(1'b1);
		// Impulse and its tail
		sampleStep(1'b1, 16'sh4000);
		repeat (12) sampleStep(1'b1, '0);
		repeat (20) sampleStep(1'b1, 16'sh2000);
		repeat (100) sampleStep(1'b1, randomSample());
		flush();
	endtask

	task automatic testCoefUpdate();
		wideSample c;
		for (int i = 0; i < 10; i++) begin
			if (i == 2) begin
				// Bits above 26 are dropped
				writeReg(coefAddr(i), 32'hF800_0000, 4'hF);
			end else if (i == 3) begin
				writeReg(coefAddr(i), 32'hFFE0_1234, 4'b1100);
				readCheck(coefAddr(i), 32'hFFE0_2F9B);
				writeReg(coefAddr(i), 32'hABCD_0000, 4'b0011);
			end else begin
				c = newCoef(i);
				writeReg(coefAddr(i), {{5{c[26]}}, c}, 4'hF);
			end
		end
		for (int i = 0; i < 10; i++) begin
			coefCheck(i, newCoef(i));
			modelCoef[i] = longint'(newCoef(i));
		end
		repeat (100) sampleStep(1'b1, randomSample());
		flush();
	endtask

	task automatic testPower();
		// Toggle enable so windows start at zero
		setEnable(1'b0);
		setEnable(1'b1);
		repeat (Window) sampleStep(1'b1, smallSample());
		flush();
		repeat (Window) sampleStep(1'b1, 16'sh0001);
		flush();
		repeat (Window) sampleStep(1'b1, 16'sh7FFF);
		flush();
		comparePower(power, 11'h7FF, "power");
	endtask

	task automatic testAxiErrors();
		logic [31:0] data;
		logic [1:0] resp;
		axiWrite(8'h40, 32'hDEAD_BEEF, 4'hF, 5, resp);
		compareResp(resp, 2'b10, "bresp");
		axiRead(8'h40, 5, data, resp);
		compareResp(resp, 2'b10, "rresp");
		compareReg(data, 32'h0, "rdata");
		// Mapped read under back-pressure
		axiRead(coefAddr(5), 4, data, resp);
		compareResp(resp, 2'b00, "rresp");
		compareReg(data, 32'h0060_0000, "rdata");
		readCheck(8'h00, 32'h1);
	endtask

	task automatic testDisable();
		repeat (40) sampleStep(1'b1, randomSample());
		flush();
		setEnable(1'b0);
		repeat (10) sampleStep(1'b1, randomSample());
		flush();
		// Histories restart from zero
		setEnable(1'b1);
		repeat (30) sampleStep(1'b1, randomSample());
		flush();
	endtask

	initial begin
		axiReq = '0;
		audIn = '0;
		audInValid = 1'b0;
		reset = 1'b1;
		lcgState = 32'hb421_b431;
		modelEnable = 1'b0;
		for (int i = 0; i < 2; i++) begin
			pipeValid[i] = 1'b0;
			pipeData[i] = '0;
		end
		for (int i = 0; i < 10; i++) begin
			modelCoef[i] = longint'(defaultCoef(i));
		end
		clearModel();
		repeat (3) @(negedge aud_clk);
		reset = 1'b0;
		testResetState();
		testDefaultResponse();
		testCoefUpdate();
		testPower();
		testAxiErrors();
		testDisable();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/audFilter_checker.sv
`default_nettype none

module audFilter_checker import audFilterPkg::*; (
	input logic aud_clk,
	input logic reset,
	input logic enable,
	input axiLiteReq axiReq,
	input axiLiteRsp axiRsp,
	input logic audInValid,
	input logic audOutValid,
	input wideSample audOut,
	input logic [PowerWidth-1:0] power
);

	// Output strobe two cycles behind the input, enable high throughout
	assert property (@(posedge aud_clk) disable iff (reset)
		audOutValid == ($past(audInValid, 2) && $past(enable, 2) && $past(enable) && enable))
		else $error("audOutValid not two cycles after audInValid");

	// Write response held until bready
	assert property (@(posedge aud_clk) disable iff (reset)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid && $stable(axiRsp.bresp))
		else $error("bvalid dropped or bresp changed before bready");

	// Read response held until rready
	assert property (@(posedge aud_clk) disable iff (reset)
		axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid && $stable(axiRsp.rdata))
		else $error("rvalid dropped or rdata changed before rready");

	// Cleared sections and meter still quiet the cycle after a disabled one
	assert property (@(posedge aud_clk) disable iff (reset)
		!$past(enable) |-> audOut == '0 && power == '0 && !audOutValid)
		else $error("Outputs not zero after a disabled cycle");

endmodule

`default_nettype wire

// File: rtl/audFilterTop.sv
`default_nettype none

module audFilterTop import audFilterPkg::*; #(
	parameter int PowerWindow = 9600,
	parameter int PowerShift = 26
) (
	input logic aud_clk,
	input logic reset,
	input axiLiteReq axiReq,
	output axiLiteRsp axiRsp,
	input logic signed [SampleWidth-1:0] audIn,
	input logic audInValid,
	output wideSample audOut,
	output logic audOutValid,
	output logic [PowerWidth-1:0] power
);

	coefBank coefs;
	logic enable;

	// AXI4-Lite register block
	coefRegs i_coefRegs (
		.aud_clk(aud_clk),
		.reset(reset),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.coefs(coefs),
		.enable(enable)
	);

	// Filter cascade and power meter
	lowPassChannel #(
		.PowerWindow(PowerWindow),
		.PowerShift(PowerShift)
	) i_channel (
		.aud_clk(aud_clk),
		.reset(reset),
		.enable(enable),
		.coefs(coefs),
		.audIn(audIn),
		.audInValid(audInValid),
		.audOut(audOut),
		.audOutValid(audOutValid),
		.power(power)
	);

endmodule

`default_nettype wire

// File: rtl/lowPassChannel.sv
`default_nettype none

module lowPassChannel import audFilterPkg::*; #(
	parameter int PowerWindow = 9600,
	parameter int PowerShift = 26
) (
	input logic aud_clk,
	input logic reset,
	input logic enable,
	input coefBank coefs,
	input logic signed [SampleWidth-1:0] audIn,
	input logic audInValid,
	output wideSample audOut,
	output logic audOutValid,
	output logic [PowerWidth-1:0] power
);

	// 8 fraction bits below the 16-bit sample
	localparam int InFrac = 8;
	localparam int SignPad = WideWidth - SampleWidth - InFrac;

	// stage[0] is the widened input, last entry the filter output
	audStream stage [NumSections + 1];
	logic clear;
	logic [PowerWidth-1:0] meterPower;

	// Disabled means histories and meter held at zero
	assign clear = !enable;

	assign stage[0] = '{
		valid: audInValid && enable,
		data: {{SignPad{audIn[SampleWidth-1]}}, audIn, {InFrac{1'b0}}}
	};

	// Biquad cascade
	for (genvar s = 0; s < NumSections; s++) begin : gSection
		biquadSection i_section (
			.aud_clk(aud_clk),
			.reset(reset),
			.clear(clear),
			.coefs(coefs[s]),
			.in(stage[s]),
			.out(stage[s + 1])
		);
	end

	powerMeter #(
		.PowerWindow(PowerWindow),
		.PowerShift(PowerShift)
	) i_powerMeter (
		.aud_clk(aud_clk),
		.reset(reset),
		.clear(clear),
		.sample(stage[NumSections]),
		.power(meterPower)
	);

	// Zero outputs as soon as enable drops
	assign audOut = enable ? stage[NumSections].data : '0;
	assign audOutValid = enable && stage[NumSections].valid;
	assign power = enable ? meterPower : '0;

endmodule

`default_nettype wire

// File: rtl/coefRegs.sv
`default_nettype none

module coefRegs import audFilterPkg::*; (
	input logic aud_clk,
	input logic reset,
	input axiLiteReq axiReq,
	output axiLiteRsp axiRsp,
	output coefBank coefs,
	output logic enable
);

	localparam int IdxWidth = $clog2(NumCoefs);
	localparam int StrbWidth = AxiDataWidth / 8;

	// Flat coefficient store, index = section * 5 + tap
	wideSample coefMem [NumCoefs];

	logic wrAccept;
	logic rdAccept;
	logic wrCtrl;
	logic wrCoef;
	logic rdCtrl;
	logic rdCoef;
	logic [IdxWidth-1:0] wrIdx;
	logic [IdxWidth-1:0] rdIdx;
	logic [AxiDataWidth-1:0] wrOld;
	logic [AxiDataWidth-1:0] wrWord;
	logic [AxiDataWidth-1:0] rdWord;

	logic bvalid;
	logic rvalid;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic [AxiDataWidth-1:0] rdata;

	// Word aligned and inside the coefficient window
	function automatic logic isCoefAddr(input logic [AxiAddrWidth-1:0] addr);
		return addr[1:0] == 2'b00 && addr >= RegCoefBase &&
			addr < RegCoefBase + AxiAddrWidth'(4 * NumCoefs);
	endfunction

	function automatic logic [IdxWidth-1:0] coefIndex(input logic [AxiAddrWidth-1:0] addr);
		logic [AxiAddrWidth-1:0] offset;
		offset = addr - RegCoefBase;
		return offset[IdxWidth+1:2];
	endfunction

	function automatic logic [AxiDataWidth-1:0] signExtend(input wideSample c);
		return {{(AxiDataWidth - WideWidth){c[WideWidth-1]}}, c};
	endfunction

	// Byte lanes follow wstrb
	function automatic logic [AxiDataWidth-1:0] mergeBytes(
		input logic [AxiDataWidth-1:0] old,
		input logic [AxiDataWidth-1:0] data,
		input logic [StrbWidth-1:0] strb
	);
		logic [AxiDataWidth-1:0] merged;
		merged = old;
		for (int b = 0; b < StrbWidth; b++) begin
			if (strb[b]) begin
				merged[8*b +: 8] = data[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// Pick one tap out of the packed reset bank
	function automatic wideSample bankTap(input coefBank bank, input int idx);
		sosCoefs sec;
		sec = bank[idx / SosTaps];
		case (idx % SosTaps)
			0: return sec.b0;
			1: return sec.b1;
			2: return sec.b2;
			3: return sec.a1;
			default: return sec.a2;
		endcase
	endfunction

	// One write in flight, address and data together
	assign wrAccept = axiReq.awvalid && axiReq.wvalid && !bvalid;
	assign rdAccept = axiReq.arvalid && !rvalid;

	// Write decode and byte merge
	always_comb begin
		wrCtrl = axiReq.awaddr == RegCtrl;
		wrCoef = isCoefAddr(axiReq.awaddr);
		wrIdx = coefIndex(axiReq.awaddr);
		wrOld = '0;
		if (wrCtrl) begin
			wrOld = {{(AxiDataWidth - 1){1'b0}}, enable};
		end else if (wrCoef) begin
			wrOld = signExtend(coefMem[wrIdx]);
		end
		wrWord = mergeBytes(wrOld, axiReq.wdata, axiReq.wstrb);
	end

	// Read decode, unmapped reads return zero
	always_comb begin
		rdCtrl = axiReq.araddr == RegCtrl;
		rdCoef = isCoefAddr(axiReq.araddr);
		rdIdx = coefIndex(axiReq.araddr);
		rdWord = '0;
		if (rdCtrl) begin
			rdWord = {{(AxiDataWidth - 1){1'b0}}, enable};
		end else if (rdCoef) begin
			rdWord = signExtend(coefMem[rdIdx]);
		end
	end

	// Control state, handshakes and coefficient store
	always_ff @(posedge aud_clk) begin
		if (reset) begin
			enable <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			for (int i = 0; i < NumCoefs; i++) begin
				coefMem[i] <= bankTap(DefaultCoefs, i);
			end
		end else begin
			if (wrAccept) begin
				bvalid <= 1'b1;
				if (wrCtrl) begin
					enable <= wrWord[0];
				end
				// Only the low 27 bits are kept
				if (wrCoef) begin
					coefMem[wrIdx] <= wrWord[WideWidth-1:0];
				end
			end else if (axiReq.bready) begin
				bvalid <= 1'b0;
			end
			if (rdAccept) begin
				rvalid <= 1'b1;
			end else if (axiReq.rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// Response payload
	always_ff @(posedge aud_clk) begin
		if (wrAccept) begin
			bresp <= (wrCtrl || wrCoef) ? RespOkay : RespSlvErr;
		end
		if (rdAccept) begin
			rresp <= (rdCtrl || rdCoef) ? RespOkay : RespSlvErr;
			rdata <= rdWord;
		end
	end

	assign axiRsp.awready = wrAccept;
	assign axiRsp.wready = wrAccept;
	assign axiRsp.bvalid = bvalid;
	assign axiRsp.bresp = bresp;
	assign axiRsp.arready = !rvalid;
	assign axiRsp.rvalid = rvalid;
	assign axiRsp.rdata = rdata;
	assign axiRsp.rresp = rresp;

	// Repack the flat store per section
	for (genvar s = 0; s < NumSections; s++) begin : gBank
		assign coefs[s] = '{
			b0: coefMem[s * SosTaps],
			b1: coefMem[s * SosTaps + 1],
			b2: coefMem[s * SosTaps + 2],
			a1: coefMem[s * SosTaps + 3],
			a2: coefMem[s * SosTaps + 4]
		};
	end

endmodule

`default_nettype wire

// File: rtl/powerMeter.sv
`default_nettype none

module powerMeter import audFilterPkg::*; #(
	parameter int PowerWindow = 9600,
	parameter int PowerShift = 26
) (
	input logic aud_clk,
	input logic reset,
	input logic clear,
	input audStream sample,
	output logic [PowerWidth-1:0] power
);

	localparam int CountWidth = $clog2(PowerWindow + 1);
	localparam int SumWidth = 40;
	localparam int MaxPower = 2 ** PowerWidth - 1;

	logic [CountWidth-1:0] count;
	logic [SumWidth-1:0] sum;
	logic [SumWidth-1:0] sumNext;
	logic [SumWidth-1:0] sumShift;
	// Unsigned magnitude, -2^26 still fits in 27 bits
	logic [WideWidth-1:0] mag;
	logic windowDone;

	// True two's complement absolute value
	assign mag = sample.data[WideWidth-1] ? (~sample.data + 1'b1) : sample.data;

	// Sum including the current sample
	assign sumNext = sum + SumWidth'(mag);
	assign sumShift = sumNext >> PowerShift;

	// Last sample of the window
	assign windowDone = count == CountWidth'(PowerWindow - 1);

	always_ff @(posedge aud_clk) begin
		if (reset || clear) begin
			count <= '0;
			sum <= '0;
			power <= '0;
		end else if (sample.valid) begin
			if (windowDone) begin
				count <= '0;
				sum <= '0;
				// Saturate to 11 bits
				if (sumShift > SumWidth'(MaxPower)) begin
					power <= '1;
				end else begin
					power <= sumShift[PowerWidth-1:0];
				end
			end else begin
				count <= count + 1'b1;
				sum <= sumNext;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/biquadSection.sv
`default_nettype none

module biquadSection import audFilterPkg::*; (
	input logic aud_clk,
	input logic reset,
	input logic clear,
	input sosCoefs coefs,
	input audStream in,
	output audStream out
);

	// Five 54-bit products plus sum growth
	localparam int AccWidth = 2 * WideWidth + 3;

	// Local signed copies of the taps
	wideSample b0;
	wideSample b1;
	wideSample b2;
	wideSample a1;
	wideSample a2;

	// Input history
	wideSample x0;
	wideSample x1;
	wideSample x2;
	// Output history, y1 doubles as the registered output
	wideSample y1;
	wideSample y2;

	wideSample yNew;
	logic outValid;
	logic signed [AccWidth-1:0] acc;
	logic signed [AccWidth-1:0] accShift;

	assign b0 = coefs.b0;
	assign b1 = coefs.b1;
	assign b2 = coefs.b2;
	assign a1 = coefs.a1;
	assign a2 = coefs.a2;
	assign x0 = in.data;

	// Direct form I, a0 normalized to one
	always_comb begin
		acc = b0 * x0 + b1 * x1 + b2 * x2 - a1 * y1 - a2 * y2;
	end

	// Drop the Q23 fraction, keep low 27 bits
	assign accShift = acc >>> CoefFrac;
	assign yNew = accShift[WideWidth-1:0];

	always_ff @(posedge aud_clk) begin
		if (reset || clear) begin
			x1 <= '0;
			x2 <= '0;
			y1 <= '0;
			y2 <= '0;
			outValid <= 1'b0;
		end else begin
			outValid <= in.valid;
			// Histories only move on a sample
			if (in.valid) begin
				x1 <= x0;
				x2 <= x1;
				y1 <= yNew;
				y2 <= y1;
			end
		end
	end

	// Output one cycle behind the input strobe
	assign out = '{valid: outValid, data: y1};

endmodule

`default_nettype wire

// File: rtl/audFilterPkg.sv
`default_nettype none

package audFilterPkg;

	// Audio widths
	localparam int SampleWidth = 16;
	localparam int WideWidth = 27;
	// Q3.23 coefficients, 1.0 is 800000 hex
	localparam int CoefFrac = 23;
	localparam int PowerWidth = 11;

	// Two biquads with five stored taps each, a0 implied
	localparam int NumSections = 2;
	localparam int SosTaps = 5;
	localparam int NumCoefs = NumSections * SosTaps;

	localparam int AxiAddrWidth = 8;
	localparam int AxiDataWidth = 32;

	typedef logic signed [WideWidth-1:0] wideSample;

	typedef struct packed {
		wideSample b0;
		wideSample b1;
		wideSample b2;
		wideSample a1;
		wideSample a2;
	} sosCoefs;

	typedef sosCoefs [NumSections-1:0] coefBank;

	typedef struct packed {
		logic valid;
		wideSample data;
	} audStream;

	typedef struct packed {
		logic awvalid;
		logic [AxiAddrWidth-1:0] awaddr;
		logic wvalid;
		logic [AxiDataWidth-1:0] wdata;
		logic [AxiDataWidth/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [AxiAddrWidth-1:0] araddr;
		logic rready;
	} axiLiteReq;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [AxiDataWidth-1:0] rdata;
		logic [1:0] rresp;
	} axiLiteRsp;

	// Register map
	localparam logic [AxiAddrWidth-1:0] RegCtrl = 8'h00;
	localparam logic [AxiAddrWidth-1:0] RegCoefBase = 8'h04;

	localparam logic [1:0] RespOkay = 2'b00;
	localparam logic [1:0] RespSlvErr = 2'b10;

	// Reset coefficient set, section 1 listed first to match [1:0] order
	localparam coefBank DefaultCoefs = '{
		'{b0: 27'h800000, b1: 27'h7000080, b2: 27'h800000,
			a1: 27'h7000D3D, a2: 27'h7FF2FA},
		'{b0: 27'h14762, b1: 27'h7FD7142, b2: 27'h14762,
			a1: 27'h7002F9B, a2: 27'h7FD076}
	};

endpackage

`default_nettype wire
